// ==== source/cpu_consts.svh ====
// Memory depth, 8080 opcode values, register codes and last execution phase
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define MEM_DEPTH    256

// Opcodes, register fields masked out of the grouped ones
`define OP_NOP       8'h00
`define OP_MVI_BASE  8'h06
`define OP_MOV_BASE  8'h40
`define OP_ADD_BASE  8'h80
`define OP_SUB_BASE  8'h90
`define OP_JMP       8'hC3
`define OP_STA       8'h32
`define OP_HLT       8'h76

`define REG_A        3'd7
`define REG_M        3'd6   // Memory operand, not supported

`define LAST_PHASE   2'd2

`endif

// ==== source/cpu_pkg.sv ====
// Data, address, phase and register-code types plus the sequencer state enum
package cpu_pkg;

    typedef logic [7:0] data_t;
    typedef logic [7:0] addr_t;

    // 0 opcode fetch, 1 operand fetch, 2 execute
    typedef logic [1:0] phase_t;

    // 8080 register field, B C D E H L M A
    typedef logic [2:0] reg_code_t;

    typedef enum logic [2:0] {
        IDLE,
        BUS_WAIT,
        READ_WAIT,
        STEP,
        HALTED
    } seq_state_t;

endpackage

// ==== source/cpu_decoder.sv ====
// Instruction decoder turning opcode and phase into datapath and bus strobes
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_decoder (
    input  logic               en,
    input  cpu_pkg::data_t     ir,
    input  cpu_pkg::phase_t    phase,
    output logic               needs_read,
    output logic               needs_write,
    output logic               pc_inc,
    output logic               ir_load,
    output logic               opr_load,
    output logic               reg_write,
    output cpu_pkg::reg_code_t reg_dst,
    output cpu_pkg::reg_code_t reg_src,
    output logic               src_is_opr,
    output logic               alu_add,
    output logic               invert_in,
    output logic               pc_load,
    output logic               addr_from_opr,
    output logic               halt,
    output logic               last
);
    logic is_mvi;
    logic is_sta;
    logic is_mov;
    logic is_hlt;
    logic is_add;
    logic is_sub;
    logic is_jmp;
    logic is_alu;
    logic has_opr;
    logic ph_fetch;
    logic ph_opr;
    logic ph_exec;

    // Group select on the top two bits, then each group looks at its own fields
    always_comb begin
        is_mvi = 1'b0;
        is_sta = 1'b0;
        is_mov = 1'b0;
        is_hlt = 1'b0;
        is_add = 1'b0;
        is_sub = 1'b0;
        is_jmp = 1'b0;
        case (ir[7:6])
            2'b00: begin
                is_mvi = ((ir & 8'hC7) == `OP_MVI_BASE) && (ir[5:3] != `REG_M);
                is_sta = ir == `OP_STA;
            end
            2'b01: begin
                is_hlt = ir == `OP_HLT;
                is_mov = ((ir & 8'hC0) == `OP_MOV_BASE) && (ir[5:3] != `REG_M)
                         && (ir[2:0] != `REG_M);
            end
            2'b10: begin
                is_add = ((ir & 8'hF8) == `OP_ADD_BASE) && (ir[2:0] != `REG_M);
                is_sub = ((ir & 8'hF8) == `OP_SUB_BASE) && (ir[2:0] != `REG_M);
            end
            default: begin
                is_jmp = ir == `OP_JMP;
            end
        endcase
    end

    assign is_alu  = is_add | is_sub;
    assign has_opr = is_mvi | is_sta | is_jmp;   // Two-byte instructions

    assign ph_fetch = phase == 2'd0;
    assign ph_opr   = phase == 2'd1;
    assign ph_exec  = phase == `LAST_PHASE;

    // Bus side, held for the whole phase
    assign needs_read    = ph_fetch | (ph_opr & has_opr);
    assign needs_write   = ph_exec & is_sta;
    assign addr_from_opr = ph_exec & is_sta;

    // Datapath strobes fire only on the step cycle
    assign ir_load   = en & ph_fetch;
    assign opr_load  = en & ph_opr & has_opr;
    assign pc_inc    = en & needs_read;
    assign reg_write = en & ph_exec & (is_mvi | is_mov | is_alu);
    assign pc_load   = en & ph_exec & is_jmp;

    assign reg_dst    = is_alu ? `REG_A : ir[5:3];
    assign reg_src    = ir[2:0];
    assign src_is_opr = is_mvi;
    assign alu_add    = is_alu;
    assign invert_in  = is_sub;   // Also the carry-in

    assign halt = ph_exec & is_hlt;
    assign last = ph_exec;

endmodule

// ==== source/cpu_datapath.sv ====
// Register file, PC, instruction and operand registers and the adder
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_datapath (
    input  logic               clk,
    input  logic               rst,
    input  logic               run,
    input  cpu_pkg::data_t     mem_rdata,
    input  logic               cpu_rvalid,
    input  logic               ir_load,
    input  logic               opr_load,
    input  logic               pc_inc,
    input  logic               pc_load,
    input  logic               reg_write,
    input  cpu_pkg::reg_code_t reg_dst,
    input  cpu_pkg::reg_code_t reg_src,
    input  logic               src_is_opr,
    input  logic               alu_add,
    input  logic               invert_in,
    input  logic               addr_from_opr,
    output cpu_pkg::data_t     ir,
    output cpu_pkg::addr_t     cpu_addr,
    output cpu_pkg::data_t     cpu_wdata
);
    cpu_pkg::data_t regs [8];   // Indexed by register code, M slot idle
    cpu_pkg::addr_t pc;
    cpu_pkg::data_t opr;
    cpu_pkg::data_t src_val;
    cpu_pkg::data_t alu_in;
    cpu_pkg::data_t sum;
    cpu_pkg::data_t result;

    assign src_val = src_is_opr ? opr : regs[reg_src];

    // SUB is A + ~src + 1
    assign alu_in = invert_in ? ~src_val : src_val;
    assign sum    = regs[`REG_A] + alu_in + {7'd0, invert_in};
    assign result = alu_add ? sum : src_val;

    assign cpu_addr  = addr_from_opr ? opr : pc;
    assign cpu_wdata = regs[`REG_A];   // STA stores the accumulator

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write) begin
            regs[reg_dst] <= result;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || run) begin
            pc <= '0;
        end else if (pc_load) begin
            pc <= opr;
        end else if (pc_inc) begin
            pc <= pc + 8'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ir <= `OP_NOP;
        end else if (ir_load && cpu_rvalid) begin
            ir <= mem_rdata;
        end
    end

    // Immediate or address byte
    always_ff @(posedge clk) begin
        if (rst) begin
            opr <= '0;
        end else if (opr_load && cpu_rvalid) begin
            opr <= mem_rdata;
        end
    end

    // Decoder must never pick the memory operand as a destination
    assert property (@(posedge clk) disable iff (rst) reg_write |-> reg_dst != `REG_M);

endmodule

// ==== source/cpu_sequencer.sv ====
// Phase counter and bus request FSM for the core
`timescale 1ns/1ps

module cpu_sequencer (
    input  logic            clk,
    input  logic            rst,
    input  logic            run,
    input  logic            needs_read,
    input  logic            needs_write,
    input  logic            last,
    input  logic            halt,
    input  logic            cpu_gnt,
    input  logic            cpu_rvalid,
    output cpu_pkg::phase_t phase,
    output logic            cpu_req,
    output logic            step,
    output logic            halted
);
    cpu_pkg::seq_state_t state;
    logic                bus;
    logic                active;

    assign bus    = needs_read | needs_write;
    assign active = (state == cpu_pkg::STEP) || (state == cpu_pkg::BUS_WAIT);

    assign cpu_req = active && bus;

    // Phase done: no-bus execute, granted write, or read data back
    assign step = (active && !bus)
                  || (active && cpu_gnt && needs_write)
                  || ((state == cpu_pkg::READ_WAIT) && cpu_rvalid);

    assign halted = state == cpu_pkg::HALTED;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cpu_pkg::IDLE;
            phase <= '0;
        end else if (run) begin
            state <= cpu_pkg::STEP;   // Restart at opcode fetch
            phase <= '0;
        end else if (step) begin
            phase <= last ? 2'd0 : phase + 2'd1;
            state <= halt ? cpu_pkg::HALTED : cpu_pkg::STEP;
        end else if (active && cpu_gnt) begin
            state <= cpu_pkg::READ_WAIT;
        end else if (active && bus) begin
            state <= cpu_pkg::BUS_WAIT;   // Lost arbitration, keep asking
        end
    end

    // A halted core stays off the bus until the next run
    assert property (@(posedge clk) disable iff (rst) halted && !run |=> !cpu_req);

endmodule

// ==== source/mem_arbiter.sv ====
// Round-robin arbiter for core and host on the single memory port
`timescale 1ns/1ps

module mem_arbiter (
    input  logic           clk,
    input  logic           rst,
    input  logic           cpu_req,
    input  logic           cpu_we,
    input  cpu_pkg::addr_t cpu_addr,
    input  cpu_pkg::data_t cpu_wdata,
    input  logic           host_req,
    input  logic           host_we,
    input  cpu_pkg::addr_t host_addr,
    input  cpu_pkg::data_t host_wdata,
    output logic           cpu_gnt,
    output logic           cpu_rvalid,
    output logic           host_gnt,
    output logic           host_rvalid,
    output logic           mem_en,
    output logic           mem_we,
    output cpu_pkg::addr_t mem_addr,
    output cpu_pkg::data_t mem_wdata
);
    logic last_cpu;   // Core won the previous grant
    logic rd_valid;
    logic rd_cpu;

    assign cpu_gnt  = cpu_req && (!host_req || !last_cpu);
    assign host_gnt = host_req && !cpu_gnt;

    assign mem_en    = cpu_gnt | host_gnt;
    assign mem_we    = (cpu_gnt & cpu_we) | (host_gnt & host_we);
    assign mem_addr  = cpu_gnt ? cpu_addr : host_addr;
    assign mem_wdata = cpu_gnt ? cpu_wdata : host_wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_cpu <= 1'b0;
        end else if (mem_en) begin
            last_cpu <= cpu_gnt;
        end
    end

    // Remember who issued the read so the data goes back to them
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= mem_en && !mem_we;
        end
        rd_cpu <= cpu_gnt;
    end

    assign cpu_rvalid  = rd_valid & rd_cpu;
    assign host_rvalid = rd_valid & ~rd_cpu;

    assert property (@(posedge clk) disable iff (rst) !(cpu_gnt && host_gnt));

endmodule

// ==== source/sync_mem.sv ====
// 256 x 8 synchronous RAM with registered read data
`timescale 1ns/1ps
`include "cpu_consts.svh"

module sync_mem (
    input  logic           clk,
    input  logic           mem_en,
    input  logic           mem_we,
    input  cpu_pkg::addr_t mem_addr,
    input  cpu_pkg::data_t mem_wdata,
    output cpu_pkg::data_t mem_rdata
);
    cpu_pkg::data_t mem [`MEM_DEPTH];

    // Read and write are never issued in the same cycle
    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_we) begin
                mem[mem_addr] <= mem_wdata;
            end else begin
                mem_rdata <= mem[mem_addr];   // One-cycle read
            end
        end
    end

endmodule

// ==== source/cpu_system.sv ====
// Top level with core, memory arbiter, RAM and host port
`timescale 1ns/1ps

module cpu_system (
    input  logic           clk,
    input  logic           rst,
    input  logic           run,
    output logic           halted,
    input  logic           host_req,
    input  logic           host_we,
    input  cpu_pkg::addr_t host_addr,
    input  cpu_pkg::data_t host_wdata,
    output logic           host_gnt,
    output cpu_pkg::data_t host_rdata,
    output logic           host_rvalid
);
    cpu_pkg::data_t     ir;
    cpu_pkg::phase_t    phase;
    cpu_pkg::reg_code_t reg_dst;
    cpu_pkg::reg_code_t reg_src;
    cpu_pkg::addr_t     cpu_addr;
    cpu_pkg::data_t     cpu_wdata;
    cpu_pkg::addr_t     mem_addr;
    cpu_pkg::data_t     mem_wdata;
    cpu_pkg::data_t     mem_rdata;
    logic               needs_read;
    logic               cpu_we;
    logic               pc_inc;
    logic               ir_load;
    logic               opr_load;
    logic               reg_write;
    logic               src_is_opr;
    logic               alu_add;
    logic               invert_in;
    logic               pc_load;
    logic               addr_from_opr;
    logic               halt;
    logic               last;
    logic               step;
    logic               cpu_req;
    logic               cpu_gnt;
    logic               cpu_rvalid;
    logic               mem_en;
    logic               mem_we;

    // Strobes are enabled only in the cycle the sequencer completes a phase
    cpu_decoder decoder_i (
        .en            (step),
        .ir            (ir),
        .phase         (phase),
        .needs_read    (needs_read),
        .needs_write   (cpu_we),
        .pc_inc        (pc_inc),
        .ir_load       (ir_load),
        .opr_load      (opr_load),
        .reg_write     (reg_write),
        .reg_dst       (reg_dst),
        .reg_src       (reg_src),
        .src_is_opr    (src_is_opr),
        .alu_add       (alu_add),
        .invert_in     (invert_in),
        .pc_load       (pc_load),
        .addr_from_opr (addr_from_opr),
        .halt          (halt),
        .last          (last)
    );

    cpu_datapath datapath_i (
        .clk           (clk),
        .rst           (rst),
        .run           (run),
        .mem_rdata     (mem_rdata),
        .cpu_rvalid    (cpu_rvalid),
        .ir_load       (ir_load),
        .opr_load      (opr_load),
        .pc_inc        (pc_inc),
        .pc_load       (pc_load),
        .reg_write     (reg_write),
        .reg_dst       (reg_dst),
        .reg_src       (reg_src),
        .src_is_opr    (src_is_opr),
        .alu_add       (alu_add),
        .invert_in     (invert_in),
        .addr_from_opr (addr_from_opr),
        .ir            (ir),
        .cpu_addr      (cpu_addr),
        .cpu_wdata     (cpu_wdata)
    );

    cpu_sequencer sequencer_i (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .needs_read  (needs_read),
        .needs_write (cpu_we),
        .last        (last),
        .halt        (halt),
        .cpu_gnt     (cpu_gnt),
        .cpu_rvalid  (cpu_rvalid),
        .phase       (phase),
        .cpu_req     (cpu_req),
        .step        (step),
        .halted      (halted)
    );

    mem_arbiter arbiter_i (
        .clk         (clk),
        .rst         (rst),
        .cpu_req     (cpu_req),
        .cpu_we      (cpu_we),
        .cpu_addr    (cpu_addr),
        .cpu_wdata   (cpu_wdata),
        .host_req    (host_req),
        .host_we     (host_we),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .cpu_gnt     (cpu_gnt),
        .cpu_rvalid  (cpu_rvalid),
        .host_gnt    (host_gnt),
        .host_rvalid (host_rvalid),
        .mem_en      (mem_en),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata)
    );

    sync_mem mem_i (
        .clk       (clk),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    assign host_rdata = mem_rdata;   // Shared read bus, qualified by host_rvalid

endmodule

// ==== sim/cpu_system_tb.sv ====
// Testbench for cpu_system with host port tasks, reference model, program runs and assertions
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_system_tb;
    localparam int clk_period        = 8;
    localparam int cycles_per_access = 5;      // Lost grant, grant, rvalid, realign
    localparam int host_ops          = 2000;   // Fill, preload, loads, readbacks, traffic
    localparam int max_instr         = 64;     // Per program run
    localparam int num_runs          = 3;
    localparam int watchdog_cycles   = host_ops * cycles_per_access
                                       + num_runs * max_instr * 3 * cycles_per_access;

    logic           clk = 1'b0;
    logic           rst;
    logic           run;
    logic           halted;
    logic           host_req;
    logic           host_we;
    cpu_pkg::addr_t host_addr;
    cpu_pkg::data_t host_wdata;
    logic           host_gnt;
    cpu_pkg::data_t host_rdata;
    logic           host_rvalid;

    logic [7:0]  image [256];        // Expected memory contents
    logic [7:0]  model_regs [8];
    logic [7:0]  pos;                // Next program byte
    logic [15:0] lfsr = 16'd44;

    cpu_system dut_i (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .halted      (halted),
        .host_req    (host_req),
        .host_we     (host_we),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .host_gnt    (host_gnt),
        .host_rdata  (host_rdata),
        .host_rvalid (host_rvalid)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = 8'h00;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
        assert (act === exp) else begin
            $display("ERR %0t %s expected %02h actual %02h", $time, name, exp, act);
            abort_run();
        end
    endtask

    // Called and returns 1 ns after a rising edge
    task automatic host_access(input logic we, input logic [7:0] addr,
                               input logic [7:0] wdata, output logic [7:0] rdata);
        host_req   = 1'b1;
        host_we    = we;
        host_addr  = addr;
        host_wdata = wdata;
        @(negedge clk);
        while (!host_gnt) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        host_req = 1'b0;
        host_we  = 1'b0;
        rdata    = 8'h00;
        if (!we) begin
            @(negedge clk);
            rdata = host_rdata;   // rvalid pulse, checked by assertion
            @(posedge clk);
            #1;
        end
    endtask

    task automatic host_write(input logic [7:0] addr, input logic [7:0] data);
        logic [7:0] unused;
        host_access(1'b1, addr, data, unused);
        image[addr] = data;
    endtask

    task automatic check_mem(input logic [7:0] addr);
        logic [7:0] d;
        host_access(1'b0, addr, 8'h00, d);
        check_value($sformatf("mem[%02h]", addr), image[addr], d);
    endtask

    task automatic emit(input logic [7:0] b);
        host_write(pos, b);
        pos = pos + 8'd1;
    endtask

    task automatic emit_mvi(input logic [2:0] r, input logic [7:0] n);
        emit(`OP_MVI_BASE | {2'b00, r, 3'b000});
        emit(n);
    endtask

    task automatic emit_mov(input logic [2:0] d, input logic [2:0] s);
        emit(`OP_MOV_BASE | {2'b00, d, s});
    endtask

    task automatic emit_sta(input logic [7:0] a);
        emit(`OP_STA);
        emit(a);
    endtask

    // Executes the image from PC 0 until HLT, storing into the image
    task automatic model_run();
        logic [7:0] pc;
        logic [7:0] op;
        logic [7:0] arg;
        logic [2:0] d;
        logic [2:0] s;
        logic       done;
        int         n;
        pc   = 8'd0;
        done = 1'b0;
        n    = 0;
        while (!done && n < 256) begin
            op  = image[pc];
            arg = image[pc + 8'd1];
            d   = op[5:3];
            s   = op[2:0];
            if (op == `OP_HLT) begin
                done = 1'b1;
            end else if ((op & 8'hC7) == `OP_MVI_BASE && d != `REG_M) begin
                model_regs[d] = arg;
                pc = pc + 8'd2;
            end else if (op[7:6] == 2'b01 && d != `REG_M && s != `REG_M) begin
                model_regs[d] = model_regs[s];
                pc = pc + 8'd1;
            end else if ((op & 8'hF8) == `OP_ADD_BASE && s != `REG_M) begin
                model_regs[`REG_A] = model_regs[`REG_A] + model_regs[s];
                pc = pc + 8'd1;
            end else if ((op & 8'hF8) == `OP_SUB_BASE && s != `REG_M) begin
                model_regs[`REG_A] = model_regs[`REG_A] - model_regs[s];
                pc = pc + 8'd1;
            end else if (op == `OP_JMP) begin
                pc = arg;
            end else if (op == `OP_STA) begin
                image[arg] = model_regs[`REG_A];
                pc = pc + 8'd2;
            end else begin
                pc = pc + 8'd1;   // Anything else is a NOP
            end
            n++;
        end
        if (!done) begin
            $display("Reference model found no HLT within its step limit");
            abort_run();
        end
    endtask

    task automatic run_program(input logic traffic);
        logic [7:0] a;
        logic [7:0] d;
        run = 1'b1;
        @(posedge clk);
        #1;
        run = 1'b0;
        check_value("halted", 8'd0, {7'd0, halted});
        while (!halted) begin
            if (traffic && rand_bits(2) == 8'd0) begin
                a = rand_bits(6);   // Program area only, never stored to
                host_access(1'b0, a, 8'h00, d);
                check_value("host_rdata", image[a], d);
            end else begin
                @(posedge clk);
                #1;
            end
        end
        model_run();
        for (int i = 0; i < 256; i++) begin
            check_mem(i[7:0]);
        end
    endtask

    assert property (@(posedge clk) disable iff (rst) !(host_gnt && dut_i.cpu_gnt)) else begin
        $display("Core and host were granted in the same cycle at %0t", $time);
        abort_run();
    end

    assert property (@(posedge clk) disable iff (rst) host_gnt && !host_we |=> host_rvalid)
    else begin
        $display("ERR %0t host_rvalid expected 1 actual 0", $time);
        abort_run();
    end

    // Loser of a contended cycle wins the next one
    assert property (@(posedge clk) disable iff (rst) host_req && dut_i.cpu_gnt |=> host_gnt)
    else begin
        $display("Host request was not granted after a competing core grant at %0t", $time);
        abort_run();
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired before the tests completed");
        abort_run();
    end

    initial begin
        rst        = 1'b1;
        run        = 1'b0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = 8'h00;
        host_wdata = 8'h00;
        pos        = 8'h00;
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = 8'h00;
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < 256; i++) begin
            host_write(i[7:0], {i[3:0], i[7:4]} ^ 8'hA5);
        end
        for (int i = 8'h80; i < 8'hD0; i++) begin
            host_write(i[7:0], rand_bits(8));
        end
        for (int i = 0; i < 256; i++) begin
            check_mem(i[7:0]);
        end

        // Every register loaded, stored through A, then a MOV chain L to B to C to A
        pos = 8'h00;
        for (int i = 0; i < 8; i++) begin
            if (i != 6) begin
                emit_mvi(i[2:0], rand_bits(8));
            end
        end
        for (int i = 0; i < 6; i++) begin
            emit_mov(`REG_A, i[2:0]);
            emit_sta(8'h80 + i[7:0]);
        end
        emit_mov(3'd0, 3'd5);
        emit_mov(3'd1, 3'd0);
        emit_mov(`REG_A, 3'd1);
        emit_sta(8'h86);
        emit(`OP_HLT);
        run_program(1'b0);

        // ADD and SUB, an unsupported MOV M,A, then JMP over three stores
        pos = 8'h00;
        for (int i = 0; i < 4; i++) begin
            emit_mvi(i[2:0], rand_bits(8));
        end
        emit_mvi(`REG_A, rand_bits(8));
        emit(`OP_ADD_BASE | 8'd0);
        emit_sta(8'h90);
        emit(`OP_SUB_BASE | 8'd1);
        emit_sta(8'h91);
        emit(`OP_ADD_BASE | 8'd7);
        emit_sta(8'h92);
        emit(`OP_SUB_BASE | 8'd3);
        emit_sta(8'h93);
        emit(8'h77);
        emit(`OP_NOP);
        emit(`OP_JMP);
        emit(pos + 8'd7);   // Past the address byte and three STAs
        emit_sta(8'hA0);
        emit_sta(8'hA1);
        emit_sta(8'hA2);
        emit_sta(8'hA3);
        emit(`OP_HLT);
        run_program(1'b1);

        // Stored sums overwritten so the rerun has to store them again
        for (int i = 0; i < 4; i++) begin
            host_write(8'h90 + i[7:0], ~image[8'h90 + i[7:0]]);
        end
        run_program(1'b1);   // Restart from PC 0 after HLT

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== cpu_system.f ====
+incdir+source
source/cpu_pkg.sv
source/cpu_decoder.sv
source/cpu_datapath.sv
source/cpu_sequencer.sv
source/mem_arbiter.sv
source/sync_mem.sv
source/cpu_system.sv
sim/cpu_system_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the cpu_system testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module cpu_system_tb \
    --Mdir obj_dir \
    -o cpu_system_sim \
    -f cpu_system.f

./obj_dir/cpu_system_sim | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "Simulation result: pass"
else
    echo "Simulation result: fail"
    exit 1
fi
